//--- logic/board_pkg.sv
////////////////////////////////////////
// SDR board shared definitions
// Register indices, pin functions,
// widths and types for the board glue
////////////////////////////////////////
`default_nettype none

package board_pkg;

    ////////////////////////////////////////
    // Widths

    localparam int ADC_WIDTH   = 12;
    localparam int EGPIO_COUNT = 15;
    localparam int GPIO_COUNT  = 18;

    ////////////////////////////////////////
    // Types

    typedef logic [4:0]              igpo_idx_t;
    typedef logic [7:0]              igpo_byte_t;
    typedef logic [ADC_WIDTH-1:0]    adc_word_t;
    // {iqsel high word, iqsel low word}
    typedef logic [2*ADC_WIDTH-1:0]  iq_pair_t;
    // Q in 31:16, I in 15:0
    typedef logic [31:0]             dac_sample_t;
    typedef logic [EGPIO_COUNT-1:0]  egpio_vec_t;
    typedef logic [GPIO_COUNT-1:0]   gpio_vec_t;

    // TX serializer phase
    typedef enum logic {
        TX_PHASE_I = 1'b0,
        TX_PHASE_Q = 1'b1
    } tx_phase_t;

    ////////////////////////////////////////
    // Register bank byte indices

    localparam igpo_idx_t IGPO_LMS_RST     = 5'd0;
    localparam igpo_idx_t IGPO_RXMIX_EN    = 5'd1;
    localparam igpo_idx_t IGPO_TXSW        = 5'd2;
    localparam igpo_idx_t IGPO_RXSW        = 5'd3;
    localparam igpo_idx_t IGPO_BOOSTER     = 5'd7;
    localparam igpo_idx_t IGPO_LED         = 5'd8;
    // Bit 0 RX enable, bit 1 TX enable
    localparam igpo_idx_t IGPO_STREAM      = 5'd10;
    localparam igpo_idx_t IGPO_GPIO_ALT    = 5'd11;
    localparam igpo_idx_t IGPO_GPIO_OUT_LO = 5'd12;
    localparam igpo_idx_t IGPO_GPIO_OUT_HI = 5'd13;
    localparam igpo_idx_t IGPO_GPIO_OE_LO  = 5'd14;
    localparam igpo_idx_t IGPO_GPIO_OE_HI  = 5'd15;
    localparam igpo_idx_t IGPO_ENABLE_OSC  = 5'd17;

    ////////////////////////////////////////
    // Alternate function bit positions

    localparam int GPIO_FUNC_SDA     = 0;
    localparam int GPIO_FUNC_SCL     = 1;
    localparam int GPIO_FUNC_UART_TX = 3;
    localparam int GPIO_FUNC_UART_RX = 4;

endpackage

`default_nettype wire

//--- logic/igpo_decode.sv
////////////////////////////////////////
// Host register bank
// Byte writes decoded into control pins,
// stream enables and GPIO registers
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module igpo_decode (
    input  wire                    igp_clk,
    input  wire                    igp_rst,
    input  wire                    igpo_wr_i,
    input  board_pkg::igpo_idx_t   igpo_addr_i,
    input  board_pkg::igpo_byte_t  igpo_data_i,
    output logic                   lms_rst_n_o,
    output logic                   rxmix_en_o,
    output logic                   txsw_o,
    output logic                   rxsw_o,
    output logic                   dcen_o,
    output logic                   led_o,
    output logic                   enable_osc_o,
    output logic                   rx_enable_o,
    output logic                   tx_enable_o,
    output board_pkg::igpo_byte_t  gpio_alt_o,
    output board_pkg::egpio_vec_t  egpio_out_o,
    output board_pkg::egpio_vec_t  egpio_oe_o
);

    // Only the bits that drive something are kept
    always_ff @(posedge igp_clk) begin
        if (igp_rst) begin
            lms_rst_n_o  <= 1'b0;
            rxmix_en_o   <= 1'b0;
            txsw_o       <= 1'b0;
            rxsw_o       <= 1'b0;
            dcen_o       <= 1'b0;
            led_o        <= 1'b0;
            enable_osc_o <= 1'b0;
            rx_enable_o  <= 1'b0;
            tx_enable_o  <= 1'b0;
            gpio_alt_o   <= '0;
            egpio_out_o  <= '0;
            egpio_oe_o   <= '0;
        end else if (igpo_wr_i) begin
            case (igpo_addr_i)
                board_pkg::IGPO_LMS_RST:     lms_rst_n_o  <= igpo_data_i[0];
                board_pkg::IGPO_RXMIX_EN:    rxmix_en_o   <= igpo_data_i[0];
                board_pkg::IGPO_TXSW:        txsw_o       <= igpo_data_i[0];
                board_pkg::IGPO_RXSW:        rxsw_o       <= igpo_data_i[0];
                board_pkg::IGPO_BOOSTER:     dcen_o       <= igpo_data_i[0];
                board_pkg::IGPO_LED:         led_o        <= igpo_data_i[0];
                board_pkg::IGPO_ENABLE_OSC:  enable_osc_o <= igpo_data_i[0];
                board_pkg::IGPO_STREAM: begin
                    rx_enable_o <= igpo_data_i[0];
                    tx_enable_o <= igpo_data_i[1];
                end
                board_pkg::IGPO_GPIO_ALT:    gpio_alt_o   <= igpo_data_i;
                // GPIO words split over a low and a high byte
                board_pkg::IGPO_GPIO_OUT_LO: egpio_out_o[7:0]  <= igpo_data_i;
                board_pkg::IGPO_GPIO_OUT_HI: egpio_out_o[14:8] <= igpo_data_i[6:0];
                board_pkg::IGPO_GPIO_OE_LO:  egpio_oe_o[7:0]   <= igpo_data_i;
                board_pkg::IGPO_GPIO_OE_HI:  egpio_oe_o[14:8]  <= igpo_data_i[6:0];
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/rx_iq_demux.sv
////////////////////////////////////////
// RX I/Q demultiplexer
// Pairs interleaved converter words into
// 24-bit samples with a valid pulse
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module rx_iq_demux (
    input  wire                   igp_clk,
    input  wire                   igp_rst,
    input  wire                   rx_enable_i,
    input  board_pkg::adc_word_t  rxd_data_i,
    input  wire                   rxd_iqsel_i,
    output board_pkg::iq_pair_t   rx_sample_o,
    output logic                  rx_valid_o
);

    board_pkg::iq_pair_t sample_q;

    // Each word lands in the half picked by iqsel
    always_ff @(posedge igp_clk) begin
        if (igp_rst) begin
            sample_q <= '0;
        end else if (rxd_iqsel_i) begin
            sample_q[2*board_pkg::ADC_WIDTH-1:board_pkg::ADC_WIDTH] <= rxd_data_i;
        end else begin
            sample_q[board_pkg::ADC_WIDTH-1:0] <= rxd_data_i;
        end
    end

    // Pair complete once the iqsel-high word is in
    always_ff @(posedge igp_clk) begin
        if (igp_rst || !rx_enable_i) begin
            rx_valid_o <= 1'b0;
        end else begin
            rx_valid_o <= rxd_iqsel_i;
        end
    end

    assign rx_sample_o = sample_q;

endmodule

`default_nettype wire

//--- logic/tx_iq_mux.sv
////////////////////////////////////////
// TX I/Q serializer
// Sends the upper 12 bits of I then Q
// as interleaved converter words
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tx_iq_mux (
    input  wire                     igp_clk,
    input  wire                     igp_rst,
    input  wire                     tx_enable_i,
    input  board_pkg::dac_sample_t  tx_sample_i,
    input  wire                     tx_valid_i,
    output logic                    tx_ready_o,
    output board_pkg::adc_word_t    txd_data_o,
    output logic                    txd_iqsel_o
);

    board_pkg::tx_phase_t phase_q;
    board_pkg::adc_word_t data_q;

    ////////////////////////////////////////
    // Phase machine

    // Phase moves only while a sample is offered
    always_ff @(posedge igp_clk) begin
        if (igp_rst || !tx_enable_i) begin
            phase_q <= board_pkg::TX_PHASE_I;
            data_q  <= '0;
        end else if (tx_valid_i) begin
            case (phase_q)
                board_pkg::TX_PHASE_I: begin
                    // I word, upper 12 of 15:0
                    data_q  <= tx_sample_i[15:4];
                    phase_q <= board_pkg::TX_PHASE_Q;
                end
                default: begin
                    // Q word, upper 12 of 31:16
                    data_q  <= tx_sample_i[31:20];
                    phase_q <= board_pkg::TX_PHASE_I;
                end
            endcase
        end
    end

    ////////////////////////////////////////
    // Outputs

    // The I word goes out with iqsel high, so iqsel tracks the Q phase
    assign txd_iqsel_o = (phase_q == board_pkg::TX_PHASE_Q);
    assign txd_data_o  = data_q;

    // Source advances on the edge that sends Q
    assign tx_ready_o  = (phase_q == board_pkg::TX_PHASE_Q);

endmodule

`default_nettype wire

//--- logic/gpio_pin_mux.sv
////////////////////////////////////////
// User pin multiplexer
// GPIO registers or alternate functions
// for I2C, UART and stream status LEDs
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module gpio_pin_mux (
    input  board_pkg::igpo_byte_t  gpio_alt_i,
    input  board_pkg::egpio_vec_t  egpio_out_i,
    input  board_pkg::egpio_vec_t  egpio_oe_i,
    input  wire                    rx_enable_i,
    input  wire                    tx_enable_i,
    input  wire                    i2c_sda_oe_i,
    input  wire                    i2c_scl_oe_i,
    input  wire                    core_uart_txd_i,
    input  board_pkg::gpio_vec_t   user_gpio_in_i,
    input  wire                    uart_rxd_i,
    output board_pkg::gpio_vec_t   user_gpio_out_o,
    output board_pkg::gpio_vec_t   user_gpio_oe_o,
    output logic                   i2c_sda_in_o,
    output logic                   i2c_scl_in_o,
    output logic                   core_uart_rxd_o,
    output logic                   uart_txd_o
);

    logic alt_i2c;
    logic alt_uart_tx;
    logic alt_uart_rx;

    // I2C moves only when both pins are claimed
    assign alt_i2c     = gpio_alt_i[board_pkg::GPIO_FUNC_SDA] &&
                         gpio_alt_i[board_pkg::GPIO_FUNC_SCL];
    assign alt_uart_tx = gpio_alt_i[board_pkg::GPIO_FUNC_UART_TX];
    assign alt_uart_rx = gpio_alt_i[board_pkg::GPIO_FUNC_UART_RX];

    ////////////////////////////////////////
    // Pin drive

    always_comb begin
        // Pins 14:0 default to the GPIO registers, pin 15 stays off
        user_gpio_out_o        = '0;
        user_gpio_oe_o         = '0;
        user_gpio_out_o[14:0]  = egpio_out_i;
        user_gpio_oe_o[14:0]   = egpio_oe_i;

        if (alt_i2c) begin
            // I2C on pins 1:0, open drain
            user_gpio_out_o[1:0]   = 2'b00;
            user_gpio_oe_o[1:0]    = {i2c_scl_oe_i, i2c_sda_oe_i};
            // Stream LEDs are active low
            user_gpio_out_o[17:16] = {~tx_enable_i, ~rx_enable_i};
            user_gpio_oe_o[17:16]  = 2'b11;
        end else begin
            user_gpio_out_o[17:16] = 2'b00;
            user_gpio_oe_o[17:16]  = {i2c_scl_oe_i, i2c_sda_oe_i};
        end

        if (alt_uart_tx) begin
            user_gpio_out_o[board_pkg::GPIO_FUNC_UART_TX] = core_uart_txd_i;
            user_gpio_oe_o[board_pkg::GPIO_FUNC_UART_TX]  = 1'b1;
        end
    end

    ////////////////////////////////////////
    // Inputs back to the controllers

    assign i2c_sda_in_o    = alt_i2c ? user_gpio_in_i[board_pkg::GPIO_FUNC_SDA]
                                     : user_gpio_in_i[16];
    assign i2c_scl_in_o    = alt_i2c ? user_gpio_in_i[board_pkg::GPIO_FUNC_SCL]
                                     : user_gpio_in_i[17];

    assign core_uart_rxd_o = alt_uart_rx ? user_gpio_in_i[board_pkg::GPIO_FUNC_UART_RX]
                                         : uart_rxd_i;
    // Dedicated TX pin idles low while the UART sits on pin 3
    assign uart_txd_o      = alt_uart_tx ? 1'b0 : core_uart_txd_i;

endmodule

`default_nettype wire

//--- logic/sdr_board_top.sv
////////////////////////////////////////
// SDR board glue top level
// Register bank, RX and TX sample
// interfaces and user pin mux
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module sdr_board_top (
    input  wire                     igp_clk,
    input  wire                     igp_rst,

    // Host register writes
    input  wire                     igpo_wr_i,
    input  board_pkg::igpo_idx_t    igpo_addr_i,
    input  board_pkg::igpo_byte_t   igpo_data_i,

    // Front-end control
    output logic                    lms_rst_n_o,
    output logic                    rxmix_en_o,
    output logic                    txsw_o,
    output logic                    rxsw_o,
    output logic                    dcen_o,
    output logic                    led_o,
    output logic                    enable_osc_o,

    // RX converter side and samples
    input  board_pkg::adc_word_t    rxd_data_i,
    input  wire                     rxd_iqsel_i,
    output board_pkg::iq_pair_t     rx_sample_o,
    output logic                    rx_valid_o,

    // TX samples and converter side
    input  board_pkg::dac_sample_t  tx_sample_i,
    input  wire                     tx_valid_i,
    output logic                    tx_ready_o,
    output board_pkg::adc_word_t    txd_data_o,
    output logic                    txd_iqsel_o,

    // I2C and UART controller side
    input  wire                     i2c_sda_oe_i,
    input  wire                     i2c_scl_oe_i,
    output logic                    i2c_sda_in_o,
    output logic                    i2c_scl_in_o,
    input  wire                     core_uart_txd_i,
    output logic                    core_uart_rxd_o,
    input  wire                     uart_rxd_i,
    output logic                    uart_txd_o,

    // User pins
    input  board_pkg::gpio_vec_t    user_gpio_in_i,
    output board_pkg::gpio_vec_t    user_gpio_out_o,
    output board_pkg::gpio_vec_t    user_gpio_oe_o
);

    logic                  rx_enable;
    logic                  tx_enable;
    board_pkg::igpo_byte_t gpio_alt;
    board_pkg::egpio_vec_t egpio_out;
    board_pkg::egpio_vec_t egpio_oe;

    igpo_decode igpo_decode_i (
        .igp_clk      (igp_clk),
        .igp_rst      (igp_rst),
        .igpo_wr_i    (igpo_wr_i),
        .igpo_addr_i  (igpo_addr_i),
        .igpo_data_i  (igpo_data_i),
        .lms_rst_n_o  (lms_rst_n_o),
        .rxmix_en_o   (rxmix_en_o),
        .txsw_o       (txsw_o),
        .rxsw_o       (rxsw_o),
        .dcen_o       (dcen_o),
        .led_o        (led_o),
        .enable_osc_o (enable_osc_o),
        .rx_enable_o  (rx_enable),
        .tx_enable_o  (tx_enable),
        .gpio_alt_o   (gpio_alt),
        .egpio_out_o  (egpio_out),
        .egpio_oe_o   (egpio_oe)
    );

    rx_iq_demux rx_iq_demux_i (
        .igp_clk     (igp_clk),
        .igp_rst     (igp_rst),
        .rx_enable_i (rx_enable),
        .rxd_data_i  (rxd_data_i),
        .rxd_iqsel_i (rxd_iqsel_i),
        .rx_sample_o (rx_sample_o),
        .rx_valid_o  (rx_valid_o)
    );

    tx_iq_mux tx_iq_mux_i (
        .igp_clk     (igp_clk),
        .igp_rst     (igp_rst),
        .tx_enable_i (tx_enable),
        .tx_sample_i (tx_sample_i),
        .tx_valid_i  (tx_valid_i),
        .tx_ready_o  (tx_ready_o),
        .txd_data_o  (txd_data_o),
        .txd_iqsel_o (txd_iqsel_o)
    );

    // Stream enables also feed the status LEDs
    gpio_pin_mux gpio_pin_mux_i (
        .gpio_alt_i      (gpio_alt),
        .egpio_out_i     (egpio_out),
        .egpio_oe_i      (egpio_oe),
        .rx_enable_i     (rx_enable),
        .tx_enable_i     (tx_enable),
        .i2c_sda_oe_i    (i2c_sda_oe_i),
        .i2c_scl_oe_i    (i2c_scl_oe_i),
        .core_uart_txd_i (core_uart_txd_i),
        .user_gpio_in_i  (user_gpio_in_i),
        .uart_rxd_i      (uart_rxd_i),
        .user_gpio_out_o (user_gpio_out_o),
        .user_gpio_oe_o  (user_gpio_oe_o),
        .i2c_sda_in_o    (i2c_sda_in_o),
        .i2c_scl_in_o    (i2c_scl_in_o),
        .core_uart_rxd_o (core_uart_rxd_o),
        .uart_txd_o      (uart_txd_o)
    );

endmodule

`default_nettype wire

//--- test/sdr_board_assert.sv
////////////////////////////////////////
// SDR board protocol assertions
// Bound to the top level
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module sdr_board_assert (
    input wire                    igp_clk,
    input wire                    igp_rst,
    input wire                    rx_enable_i,
    input wire                    tx_enable_i,
    input wire                    tx_valid_i,
    input wire                    tx_ready_i,
    input board_pkg::adc_word_t   txd_data_i,
    input wire                    txd_iqsel_i,
    input wire                    rx_valid_i,
    input board_pkg::gpio_vec_t   gpio_oe_i
);

    // Pin 15 has no function
    pin15_off: assert property (@(posedge igp_clk) !gpio_oe_i[15])
        else $error("pin 15 output enable went high");

    // Serializer idles at zero once TX is off
    tx_idle: assert property (@(posedge igp_clk) disable iff (igp_rst)
        !tx_enable_i |=> (txd_data_i == '0 && !txd_iqsel_i))
        else $error("TX outputs not idle after disable");

    rx_quiet: assert property (@(posedge igp_clk) disable iff (igp_rst)
        !rx_enable_i |=> !rx_valid_i)
        else $error("rx_valid_o high while RX disabled");

    // Ready alternates while samples flow
    ready_alt: assert property (@(posedge igp_clk) disable iff (igp_rst)
        (tx_enable_i && tx_valid_i && tx_ready_i) |=> !tx_ready_i)
        else $error("tx_ready_o high on two edges in a row");

endmodule

bind sdr_board_top sdr_board_assert sdr_board_assert_i (
    .igp_clk     (igp_clk),
    .igp_rst     (igp_rst),
    .rx_enable_i (rx_enable),
    .tx_enable_i (tx_enable),
    .tx_valid_i  (tx_valid_i),
    .tx_ready_i  (tx_ready_o),
    .txd_data_i  (txd_data_o),
    .txd_iqsel_i (txd_iqsel_o),
    .rx_valid_i  (rx_valid_o),
    .gpio_oe_i   (user_gpio_oe_o)
);

`default_nettype wire

//--- test/sdr_board_tb.sv
////////////////////////////////////////
// SDR board glue testbench
// Register bank, RX pairing, TX serializer
// and user pin routing against a model
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module sdr_board_tb;

    localparam int WAIT_LIMIT = 20;

    logic                   igp_clk;
    logic                   igp_rst;
    logic                   igpo_wr_i;
    board_pkg::igpo_idx_t   igpo_addr_i;
    board_pkg::igpo_byte_t  igpo_data_i;
    logic                   lms_rst_n_o;
    logic                   rxmix_en_o;
    logic                   txsw_o;
    logic                   rxsw_o;
    logic                   dcen_o;
    logic                   led_o;
    logic                   enable_osc_o;
    board_pkg::adc_word_t   rxd_data_i;
    logic                   rxd_iqsel_i;
    board_pkg::iq_pair_t    rx_sample_o;
    logic                   rx_valid_o;
    board_pkg::dac_sample_t tx_sample_i;
    logic                   tx_valid_i;
    logic                   tx_ready_o;
    board_pkg::adc_word_t   txd_data_o;
    logic                   txd_iqsel_o;
    logic                   i2c_sda_oe_i;
    logic                   i2c_scl_oe_i;
    logic                   i2c_sda_in_o;
    logic                   i2c_scl_in_o;
    logic                   core_uart_txd_i;
    logic                   core_uart_rxd_o;
    logic                   uart_rxd_i;
    logic                   uart_txd_o;
    board_pkg::gpio_vec_t   user_gpio_in_i;
    board_pkg::gpio_vec_t   user_gpio_out_o;
    board_pkg::gpio_vec_t   user_gpio_oe_o;

    // Model of the register bank contents
    logic                  exp_lms;
    logic                  exp_rxmix;
    logic                  exp_txsw;
    logic                  exp_rxsw;
    logic                  exp_dcen;
    logic                  exp_led;
    logic                  exp_osc;
    logic                  m_rx_en;
    logic                  m_tx_en;
    board_pkg::igpo_byte_t m_alt;
    board_pkg::egpio_vec_t m_out;
    board_pkg::egpio_vec_t m_oe;

    logic [31:0]          lcg_state;
    logic [31:0]          rnd;
    board_pkg::adc_word_t word_a;
    board_pkg::adc_word_t word_b;
    logic                 pin_check_on;
    int                   errors;
    int                   timeouts;

    sdr_board_top dut_i (.*);

    always #50 igp_clk = ~igp_clk;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    ////////////////////////////////////////
    // Compare tasks

    task automatic check_gpio(input string name, input board_pkg::gpio_vec_t got,
                              input board_pkg::gpio_vec_t exp);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_pair(input string name, input board_pkg::iq_pair_t got,
                              input board_pkg::iq_pair_t exp);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_word(input string name, input board_pkg::adc_word_t got,
                              input board_pkg::adc_word_t exp);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    ////////////////////////////////////////
    // Reference model

    // Expected pins and controller inputs for the given register and pin state
    function automatic void ref_pins(
        input  board_pkg::igpo_byte_t alt,
        input  board_pkg::egpio_vec_t eo,
        input  board_pkg::egpio_vec_t eoe,
        input  logic rx_en,
        input  logic tx_en,
        input  logic sda_oe,
        input  logic scl_oe,
        input  logic txd,
        input  board_pkg::gpio_vec_t pins_in,
        input  logic rxd,
        output board_pkg::gpio_vec_t out,
        output board_pkg::gpio_vec_t oe,
        output logic sda_in,
        output logic scl_in,
        output logic core_rxd,
        output logic uart_txd
    );
        out = '0;
        oe  = '0;
        for (int p = 0; p < board_pkg::EGPIO_COUNT; p++) begin
            out[p] = eo[p];
            oe[p]  = eoe[p];
        end
        if (alt[board_pkg::GPIO_FUNC_SDA] && alt[board_pkg::GPIO_FUNC_SCL]) begin
            out[0]  = 1'b0;
            out[1]  = 1'b0;
            oe[0]   = sda_oe;
            oe[1]   = scl_oe;
            // LEDs lit low while a stream runs
            out[16] = ~rx_en;
            out[17] = ~tx_en;
            oe[16]  = 1'b1;
            oe[17]  = 1'b1;
            sda_in  = pins_in[0];
            scl_in  = pins_in[1];
        end else begin
            oe[16]  = sda_oe;
            oe[17]  = scl_oe;
            sda_in  = pins_in[16];
            scl_in  = pins_in[17];
        end
        uart_txd = txd;
        if (alt[board_pkg::GPIO_FUNC_UART_TX]) begin
            out[3]   = txd;
            oe[3]    = 1'b1;
            uart_txd = 1'b0;
        end
        core_rxd = alt[board_pkg::GPIO_FUNC_UART_RX] ? pins_in[4] : rxd;
    endfunction

    task automatic check_pins_now();
        board_pkg::gpio_vec_t exp_out;
        board_pkg::gpio_vec_t exp_oe;
        logic exp_sda;
        logic exp_scl;
        logic exp_rxd;
        logic exp_txd;
        ref_pins(m_alt, m_out, m_oe, m_rx_en, m_tx_en, i2c_sda_oe_i, i2c_scl_oe_i,
                 core_uart_txd_i, user_gpio_in_i, uart_rxd_i,
                 exp_out, exp_oe, exp_sda, exp_scl, exp_rxd, exp_txd);
        check_gpio("user_gpio_out_o", user_gpio_out_o, exp_out);
        check_gpio("user_gpio_oe_o", user_gpio_oe_o, exp_oe);
        check_bit("i2c_sda_in_o", i2c_sda_in_o, exp_sda);
        check_bit("i2c_scl_in_o", i2c_scl_in_o, exp_scl);
        check_bit("core_uart_rxd_o", core_uart_rxd_o, exp_rxd);
        check_bit("uart_txd_o", uart_txd_o, exp_txd);
    endtask

    // Pins are combinational, so mid-cycle is a stable point
    always @(negedge igp_clk) begin
        if (pin_check_on) begin
            check_pins_now();
        end
    end

    ////////////////////////////////////////
    // Host writes and waits

    task automatic mirror_write(input board_pkg::igpo_idx_t idx,
                                input board_pkg::igpo_byte_t val);
        case (idx)
            board_pkg::IGPO_LMS_RST:     exp_lms = val[0];
            board_pkg::IGPO_RXMIX_EN:    exp_rxmix = val[0];
            board_pkg::IGPO_TXSW:        exp_txsw = val[0];
            board_pkg::IGPO_RXSW:        exp_rxsw = val[0];
            board_pkg::IGPO_BOOSTER:     exp_dcen = val[0];
            board_pkg::IGPO_LED:         exp_led = val[0];
            board_pkg::IGPO_ENABLE_OSC:  exp_osc = val[0];
            board_pkg::IGPO_STREAM: begin
                m_rx_en = val[0];
                m_tx_en = val[1];
            end
            board_pkg::IGPO_GPIO_ALT:    m_alt = val;
            board_pkg::IGPO_GPIO_OUT_LO: m_out[7:0] = val;
            board_pkg::IGPO_GPIO_OUT_HI: m_out[14:8] = val[6:0];
            board_pkg::IGPO_GPIO_OE_LO:  m_oe[7:0] = val;
            board_pkg::IGPO_GPIO_OE_HI:  m_oe[14:8] = val[6:0];
            default: ;
        endcase
    endtask

    // Called 1 ns after an edge, returns 1 ns after the write edge
    task automatic write_reg(input board_pkg::igpo_idx_t idx,
                             input board_pkg::igpo_byte_t val);
        igpo_wr_i   = 1'b1;
        igpo_addr_i = idx;
        igpo_data_i = val;
        @(posedge igp_clk);
        #1;
        igpo_wr_i = 1'b0;
        mirror_write(idx, val);
    endtask

    task automatic check_controls();
        check_bit("lms_rst_n_o", lms_rst_n_o, exp_lms);
        check_bit("rxmix_en_o", rxmix_en_o, exp_rxmix);
        check_bit("txsw_o", txsw_o, exp_txsw);
        check_bit("rxsw_o", rxsw_o, exp_rxsw);
        check_bit("dcen_o", dcen_o, exp_dcen);
        check_bit("led_o", led_o, exp_led);
        check_bit("enable_osc_o", enable_osc_o, exp_osc);
    endtask

    task automatic wait_rx_valid();
        int n;
        for (n = 0; n < WAIT_LIMIT; n++) begin
            @(posedge igp_clk);
            #1;
            if (rx_valid_o) break;
        end
        if (n == WAIT_LIMIT) begin
            timeouts++;
            $display("Timeout: rx_valid_o never went high after a word pair");
        end
    endtask

    task automatic wait_txd_iqsel(input logic level);
        int n;
        for (n = 0; n < WAIT_LIMIT; n++) begin
            @(posedge igp_clk);
            #1;
            if (txd_iqsel_o === level) break;
        end
        if (n == WAIT_LIMIT) begin
            timeouts++;
            $display("Timeout: txd_iqsel_o never reached %0d", level);
        end
    endtask

    task automatic drive_pin_inputs();
        rnd = next_rand();
        user_gpio_in_i  = rnd[17:0];
        i2c_sda_oe_i    = rnd[20];
        i2c_scl_oe_i    = rnd[21];
        core_uart_txd_i = rnd[22];
        uart_rxd_i      = rnd[23];
    endtask

    ////////////////////////////////////////
    // Stimulus

    initial begin
        int k;
        igp_clk = 1'b0;
        igp_rst = 1'b1;
        igpo_wr_i = 1'b0;
        igpo_addr_i = '0;
        igpo_data_i = '0;
        rxd_data_i = '0;
        rxd_iqsel_i = 1'b0;
        tx_sample_i = '0;
        tx_valid_i = 1'b0;
        i2c_sda_oe_i = 1'b0;
        i2c_scl_oe_i = 1'b0;
        core_uart_txd_i = 1'b0;
        uart_rxd_i = 1'b0;
        user_gpio_in_i = '0;
        {exp_lms, exp_rxmix, exp_txsw, exp_rxsw, exp_dcen, exp_led, exp_osc} = '0;
        m_rx_en = 1'b0;
        m_tx_en = 1'b0;
        m_alt = '0;
        m_out = '0;
        m_oe = '0;
        lcg_state = 32'd91;
        pin_check_on = 1'b0;
        errors = 0;
        timeouts = 0;

        repeat (8) @(posedge igp_clk);
        #1;
        igp_rst = 1'b0;

        // Reset state
        check_controls();
        check_bit("rx_valid_o", rx_valid_o, 1'b0);
        check_bit("tx_ready_o", tx_ready_o, 1'b0);
        check_gpio("user_gpio_oe_o", user_gpio_oe_o, '0);
        pin_check_on = 1'b1;

        // Every index with a random byte, then its complement
        for (k = 0; k < 32; k++) begin
            rnd = next_rand();
            write_reg(k[4:0], rnd[31:24]);
            check_controls();
            write_reg(k[4:0], ~rnd[31:24]);
            check_controls();
        end

        ////////////////////////////////////////
        // RX pairing
        write_reg(board_pkg::IGPO_STREAM, 8'h01);
        for (k = 0; k < 8; k++) begin
            rnd = next_rand();
            word_a = rnd[11:0];
            word_b = rnd[27:16];
            rxd_data_i  = word_a;
            rxd_iqsel_i = 1'b0;
            @(posedge igp_clk);
            #1;
            rxd_data_i  = word_b;
            rxd_iqsel_i = 1'b1;
            wait_rx_valid();
            check_pair("rx_sample_o", rx_sample_o, {word_b, word_a});
            rxd_iqsel_i = 1'b0;
        end
        write_reg(board_pkg::IGPO_STREAM, 8'h00);
        for (k = 0; k < 6; k++) begin
            rnd = next_rand();
            rxd_data_i  = rnd[11:0];
            rxd_iqsel_i = k[0];
            @(posedge igp_clk);
            #1;
            check_bit("rx_valid_o", rx_valid_o, 1'b0);
        end
        rxd_iqsel_i = 1'b0;

        ////////////////////////////////////////
        // TX serialization
        write_reg(board_pkg::IGPO_STREAM, 8'h02);
        for (k = 0; k < 6; k++) begin
            tx_sample_i = next_rand();
            tx_valid_i  = 1'b1;
            wait_txd_iqsel(1'b1);
            check_word("txd_data_o", txd_data_o, tx_sample_i[15:4]);
            check_bit("tx_ready_o", tx_ready_o, 1'b1);
            if (k % 2 == 1) begin
                tx_valid_i = 1'b0;
                repeat (2) begin
                    @(posedge igp_clk);
                    #1;
                    check_word("txd_data_o", txd_data_o, tx_sample_i[15:4]);
                    check_bit("txd_iqsel_o", txd_iqsel_o, 1'b1);
                end
                tx_valid_i = 1'b1;
            end
            wait_txd_iqsel(1'b0);
            check_word("txd_data_o", txd_data_o, tx_sample_i[31:20]);
            check_bit("tx_ready_o", tx_ready_o, 1'b0);
        end
        tx_valid_i = 1'b0;
        write_reg(board_pkg::IGPO_STREAM, 8'h00);
        @(posedge igp_clk);
        #1;
        check_word("txd_data_o", txd_data_o, '0);
        check_bit("txd_iqsel_o", txd_iqsel_o, 1'b0);

        ////////////////////////////////////////
        // Pin routing, GPIO then I2C alternate
        for (k = 0; k < 4; k++) begin
            rnd = next_rand();
            write_reg(board_pkg::IGPO_GPIO_OUT_LO, rnd[7:0]);
            write_reg(board_pkg::IGPO_GPIO_OUT_HI, rnd[15:8]);
            write_reg(board_pkg::IGPO_GPIO_OE_LO, rnd[23:16]);
            write_reg(board_pkg::IGPO_GPIO_OE_HI, rnd[31:24]);
            write_reg(board_pkg::IGPO_GPIO_ALT, 8'h00);
            drive_pin_inputs();
            repeat (2) @(posedge igp_clk);
            #1;
            // All four stream enable combinations on the LEDs
            write_reg(board_pkg::IGPO_STREAM, {6'd0, k[1:0]});
            write_reg(board_pkg::IGPO_GPIO_ALT, 8'h03);
            drive_pin_inputs();
            repeat (2) @(posedge igp_clk);
            #1;
        end

        // UART routing with the alternate bits off, then on
        for (k = 0; k < 8; k++) begin
            write_reg(board_pkg::IGPO_GPIO_ALT, (k < 4) ? 8'h00 : 8'h18);
            drive_pin_inputs();
            core_uart_txd_i = k[0];
            uart_rxd_i      = k[1];
            @(posedge igp_clk);
            #1;
            check_pins_now();
        end

        pin_check_on = 1'b0;
        $display("Summary: %0d value errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
logic/board_pkg.sv
logic/igpo_decode.sv
logic/rx_iq_demux.sv
logic/tx_iq_mux.sv
logic/gpio_pin_mux.sv
logic/sdr_board_top.sv
test/sdr_board_assert.sv
test/sdr_board_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := sdr_board_tb
FILELIST   := tb.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0
PASS_MSG   := Simulation completed successfully

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
